/* common/pipeline_consts.svh */
`ifndef PIPELINE_CONSTS_SVH
`define PIPELINE_CONSTS_SVH

// Datapath widths
`define DATA_WIDTH      32
`define REG_ADDR_WIDTH  5
`define NUM_REGS        32
`define IMM_WIDTH       16
`define SHAMT_WIDTH     5
`define ALU_OP_WIDTH    4

// Primary opcodes, instr[31:26]
`define OP_RTYPE  6'h00
`define OP_ADDIU  6'h09
`define OP_SLTI   6'h0a
`define OP_SLTIU  6'h0b
`define OP_ANDI   6'h0c
`define OP_ORI    6'h0d
`define OP_XORI   6'h0e
`define OP_LUI    6'h0f

// Function field of register form, instr[5:0]
`define FN_SLL    6'h00
`define FN_SRL    6'h02
`define FN_SRA    6'h03
`define FN_SLLV   6'h04
`define FN_SRLV   6'h06
`define FN_SRAV   6'h07
`define FN_ADDU   6'h21
`define FN_SUBU   6'h23
`define FN_AND    6'h24
`define FN_OR     6'h25
`define FN_XOR    6'h26
`define FN_NOR    6'h27
`define FN_SLT    6'h2a
`define FN_SLTU   6'h2b

// Execute operation select
`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_AND   4'd2
`define ALU_OR    4'd3
`define ALU_XOR   4'd4
`define ALU_NOR   4'd5
`define ALU_SLT   4'd6
`define ALU_SLTU  4'd7
`define ALU_LUI   4'd8
`define ALU_SLL   4'd9
`define ALU_SRL   4'd10
`define ALU_SRA   4'd11

`endif

/* common/pipeline_pkg.sv */
`include "pipeline_consts.svh"

package pipeline_pkg;

    // Register form: opcode rs rt rd shamt funct
    typedef struct packed {
        logic [5:0]                 opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`SHAMT_WIDTH-1:0]    shamt;
        logic [5:0]                 funct;
    } instr_r_t;

    // Immediate form: opcode rs rt imm
    typedef struct packed {
        logic [5:0]                 opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`IMM_WIDTH-1:0]      imm;
    } instr_i_t;

    // Same 32-bit word, two decodings
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

/* common/ex_bus_if.sv */
`timescale 1ns/1ps

`include "pipeline_consts.svh"

interface ex_bus_if;

    // One beat per cycle while valid is high
    logic                       valid;
    logic [`ALU_OP_WIDTH-1:0]   alu_op;
    logic [`DATA_WIDTH-1:0]     op_a;
    logic [`DATA_WIDTH-1:0]     op_b;
    logic [`DATA_WIDTH-1:0]     imm_ext;
    logic                       use_imm;
    logic [`SHAMT_WIDTH-1:0]    shamt;
    logic                       use_reg_shamt;
    logic [`REG_ADDR_WIDTH-1:0] rs_addr;
    logic [`REG_ADDR_WIDTH-1:0] rt_addr;
    logic [`REG_ADDR_WIDTH-1:0] rd_addr;

    // Decode side, ID/EX register outputs
    modport producer (
        output valid, alu_op, op_a, op_b, imm_ext, use_imm,
        output shamt, use_reg_shamt, rs_addr, rt_addr, rd_addr
    );

    // Execute side
    modport consumer (
        input valid, alu_op, op_a, op_b, imm_ext, use_imm,
        input shamt, use_reg_shamt, rs_addr, rt_addr, rd_addr
    );

endinterface

/* rtl/gpr.sv */
`timescale 1ns/1ps

`include "pipeline_consts.svh"

module gpr (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`REG_ADDR_WIDTH-1:0] rs_addr,
    input  logic [`REG_ADDR_WIDTH-1:0] rt_addr,
    input  logic                       we,
    input  logic [`REG_ADDR_WIDTH-1:0] wr_addr,
    input  logic [`DATA_WIDTH-1:0]     wr_data,
    output logic [`DATA_WIDTH-1:0]     rs_data,
    output logic [`DATA_WIDTH-1:0]     rt_data
);

    logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];
    logic                   wr_live;

    // Register zero is never written
    assign wr_live = we && (wr_addr != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports with write-through
    ////////////////////////////////////////////////////////////

    // Same-cycle write is visible to the reader
    assign rs_data = (wr_live && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_data = (wr_live && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps

`include "pipeline_consts.svh"

module decode_stage
    import pipeline_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       instr_valid,
    input  logic [`DATA_WIDTH-1:0]     instr,
    input  logic                       wb_valid,
    input  logic [`REG_ADDR_WIDTH-1:0] wb_rd_addr,
    input  logic [`DATA_WIDTH-1:0]     wb_data,
    ex_bus_if.producer                 ex_bus
);

    ////////////////////////////////////////////////////////////
    // IF/ID register
    ////////////////////////////////////////////////////////////

    logic   ifid_valid;
    instr_u ifid_instr;

    always_ff @(posedge clk) begin
        if (rst) begin
            ifid_valid <= 1'b0;
        end else begin
            ifid_valid <= instr_valid;
        end
        ifid_instr <= instr;
    end

    ////////////////////////////////////////////////////////////
    // Decoder
    ////////////////////////////////////////////////////////////

    logic                       dec_known;
    logic [`ALU_OP_WIDTH-1:0]   dec_alu_op;
    logic                       dec_use_imm;
    logic                       dec_sign_ext;
    logic                       dec_use_reg_shamt;
    logic [`REG_ADDR_WIDTH-1:0] dec_rd_addr;
    logic [`DATA_WIDTH-1:0]     dec_imm_ext;
    logic [`DATA_WIDTH-1:0]     rs_data;
    logic [`DATA_WIDTH-1:0]     rt_data;

    always_comb begin
        // Defaults, immediate form with zero extension
        dec_known         = 1'b1;
        dec_alu_op        = `ALU_ADD;
        dec_use_imm       = 1'b1;
        dec_sign_ext      = 1'b0;
        dec_use_reg_shamt = 1'b0;
        dec_rd_addr       = ifid_instr.i.rt;
        case (ifid_instr.r.opcode)
            `OP_RTYPE: begin
                dec_use_imm = 1'b0;
                dec_rd_addr = ifid_instr.r.rd;
                case (ifid_instr.r.funct)
                    `FN_SLL:  dec_alu_op = `ALU_SLL;
                    `FN_SRL:  dec_alu_op = `ALU_SRL;
                    `FN_SRA:  dec_alu_op = `ALU_SRA;
                    // Variable shifts take the amount from rs
                    `FN_SLLV: begin
                        dec_alu_op        = `ALU_SLL;
                        dec_use_reg_shamt = 1'b1;
                    end
                    `FN_SRLV: begin
                        dec_alu_op        = `ALU_SRL;
                        dec_use_reg_shamt = 1'b1;
                    end
                    `FN_SRAV: begin
                        dec_alu_op        = `ALU_SRA;
                        dec_use_reg_shamt = 1'b1;
                    end
                    `FN_ADDU: dec_alu_op = `ALU_ADD;
                    `FN_SUBU: dec_alu_op = `ALU_SUB;
                    `FN_AND:  dec_alu_op = `ALU_AND;
                    `FN_OR:   dec_alu_op = `ALU_OR;
                    `FN_XOR:  dec_alu_op = `ALU_XOR;
                    `FN_NOR:  dec_alu_op = `ALU_NOR;
                    `FN_SLT:  dec_alu_op = `ALU_SLT;
                    `FN_SLTU: dec_alu_op = `ALU_SLTU;
                    default:  dec_known = 1'b0;
                endcase
            end
            // Arithmetic and compare immediates are sign extended
            `OP_ADDIU: begin
                dec_alu_op   = `ALU_ADD;
                dec_sign_ext = 1'b1;
            end
            `OP_SLTI: begin
                dec_alu_op   = `ALU_SLT;
                dec_sign_ext = 1'b1;
            end
            `OP_SLTIU: begin
                dec_alu_op   = `ALU_SLTU;
                dec_sign_ext = 1'b1;
            end
            `OP_ANDI: dec_alu_op = `ALU_AND;
            `OP_ORI:  dec_alu_op = `ALU_OR;
            `OP_XORI: dec_alu_op = `ALU_XOR;
            `OP_LUI:  dec_alu_op = `ALU_LUI;
            // Anything else turns into a bubble
            default:  dec_known = 1'b0;
        endcase
    end

    assign dec_imm_ext = {{(`DATA_WIDTH-`IMM_WIDTH){dec_sign_ext & ifid_instr.i.imm[`IMM_WIDTH-1]}},
                          ifid_instr.i.imm};

    // Register file, write port fed from writeback
    gpr gpr_i (
        .clk     ( clk ),
        .rst     ( rst ),
        .rs_addr ( ifid_instr.r.rs ),
        .rt_addr ( ifid_instr.r.rt ),
        .we      ( wb_valid ),
        .wr_addr ( wb_rd_addr ),
        .wr_data ( wb_data ),
        .rs_data ( rs_data ),
        .rt_data ( rt_data )
    );

    ////////////////////////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_bus.valid <= 1'b0;
        end else begin
            ex_bus.valid <= ifid_valid & dec_known;
        end
        ex_bus.alu_op        <= dec_alu_op;
        ex_bus.op_a          <= rs_data;
        ex_bus.op_b          <= rt_data;
        ex_bus.imm_ext       <= dec_imm_ext;
        ex_bus.use_imm       <= dec_use_imm;
        ex_bus.shamt         <= ifid_instr.r.shamt;
        ex_bus.use_reg_shamt <= dec_use_reg_shamt;
        ex_bus.rs_addr       <= ifid_instr.r.rs;
        ex_bus.rt_addr       <= ifid_instr.r.rt;
        ex_bus.rd_addr       <= dec_rd_addr;
    end

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ps

`include "pipeline_consts.svh"

module execute_stage (
    input  logic                       clk,
    input  logic                       rst,
    ex_bus_if.consumer                 ex_bus,
    output logic                       wb_valid,
    output logic [`REG_ADDR_WIDTH-1:0] wb_rd_addr,
    output logic [`DATA_WIDTH-1:0]     wb_data
);

    ////////////////////////////////////////////////////////////
    // Forwarding from the result register
    ////////////////////////////////////////////////////////////

    logic                    fwd_a;
    logic                    fwd_b;
    logic [`DATA_WIDTH-1:0]  op_a;
    logic [`DATA_WIDTH-1:0]  op_b_reg;
    logic [`DATA_WIDTH-1:0]  op_b;
    logic [`SHAMT_WIDTH-1:0] shamt;
    logic [`DATA_WIDTH-1:0]  result;

    // Distance 1 hit, register zero excluded
    assign fwd_a = wb_valid && (wb_rd_addr != '0) && (wb_rd_addr == ex_bus.rs_addr);
    assign fwd_b = wb_valid && (wb_rd_addr != '0) && (wb_rd_addr == ex_bus.rt_addr);

    assign op_a     = fwd_a ? wb_data : ex_bus.op_a;
    assign op_b_reg = fwd_b ? wb_data : ex_bus.op_b;

    // Immediate replaces rt for the immediate form
    assign op_b = ex_bus.use_imm ? ex_bus.imm_ext : op_b_reg;

    // Variable shifts use the low bits of rs
    assign shamt = ex_bus.use_reg_shamt ? op_a[`SHAMT_WIDTH-1:0] : ex_bus.shamt;

    ////////////////////////////////////////////////////////////
    // ALU and barrel shifter
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (ex_bus.alu_op)
            `ALU_ADD:  result = op_a + op_b;
            `ALU_SUB:  result = op_a - op_b;
            `ALU_AND:  result = op_a & op_b;
            `ALU_OR:   result = op_a | op_b;
            `ALU_XOR:  result = op_a ^ op_b;
            `ALU_NOR:  result = ~(op_a | op_b);
            // Compares leave a single bit
            `ALU_SLT: begin
                result = {{(`DATA_WIDTH-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            `ALU_SLTU: begin
                result = {{(`DATA_WIDTH-1){1'b0}}, (op_a < op_b)};
            end
            // Immediate into the upper half
            `ALU_LUI: begin
                result = {op_b[`IMM_WIDTH-1:0], {(`DATA_WIDTH-`IMM_WIDTH){1'b0}}};
            end
            // Shifts always operate on rt
            `ALU_SLL:  result = op_b_reg << shamt;
            `ALU_SRL:  result = op_b_reg >> shamt;
            `ALU_SRA:  result = $unsigned($signed(op_b_reg) >>> shamt);
            default:   result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Result register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_bus.valid;
        end
        wb_rd_addr <= ex_bus.rd_addr;
        wb_data    <= result;
    end

endmodule

/* rtl/pipeline.sv */
`timescale 1ns/1ps

`include "pipeline_consts.svh"

module pipeline (
    input  logic                       clk,
    input  logic                       rst,
    // Instruction issue
    input  logic                       instr_valid,
    input  logic [`DATA_WIDTH-1:0]     instr,
    // Writeback result
    output logic                       wb_valid,
    output logic [`REG_ADDR_WIDTH-1:0] wb_rd_addr,
    output logic [`DATA_WIDTH-1:0]     wb_data
);

    ////////////////////////////////////////////////////////////
    // Decode to execute
    ////////////////////////////////////////////////////////////

    ex_bus_if ex_bus ();

    // Decode, holds IF/ID, register file and ID/EX
    decode_stage decode_i (
        .clk         ( clk ),
        .rst         ( rst ),
        .instr_valid ( instr_valid ),
        .instr       ( instr ),
        // Writeback loops back into the register file
        .wb_valid    ( wb_valid ),
        .wb_rd_addr  ( wb_rd_addr ),
        .wb_data     ( wb_data ),
        .ex_bus      ( ex_bus.producer )
    );

    // Execute, result register drives the top outputs
    execute_stage execute_i (
        .clk        ( clk ),
        .rst        ( rst ),
        .ex_bus     ( ex_bus.consumer ),
        .wb_valid   ( wb_valid ),
        .wb_rd_addr ( wb_rd_addr ),
        .wb_data    ( wb_data )
    );

endmodule

/* bench/pipeline_checker.sv */
`timescale 1ns/1ps

`include "pipeline_consts.svh"

module pipeline_checker (
    input logic                       clk,
    input logic                       rst,
    input logic                       instr_valid,
    input logic [`DATA_WIDTH-1:0]     instr,
    input logic                       wb_valid,
    input logic [`REG_ADDR_WIDTH-1:0] wb_rd_addr
);

    logic known;
    logic issued;

    // Kept opcodes and function codes, everything else is a bubble
    always_comb begin
        case (instr[31:26])
            `OP_RTYPE: begin
                case (instr[5:0])
                    `FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV,
                    `FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_NOR,
                    `FN_SLT, `FN_SLTU: known = 1'b1;
                    default: known = 1'b0;
                endcase
            end
            `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI,
            `OP_LUI: known = 1'b1;
            default: known = 1'b0;
        endcase
    end

    assign issued = instr_valid && known && !rst;

    ////////////////////////////////////////////////////////////
    // Properties
    ////////////////////////////////////////////////////////////

    // Reset clears the result register
    reset_clears_wb: assert property (@(posedge clk) rst |=> !wb_valid)
        else $error("wb_valid high after a reset cycle");

    // Fixed two cycle latency, bubbles dropped
    // Result register loads two edges after issue, sampled one edge later
    wb_follows_issue: assert property (@(posedge clk) disable iff (rst)
        wb_valid == ($past(issued, 3) && $past(!rst, 1)))
        else $error("wb_valid does not follow instr_valid two cycles earlier");

    wb_addr_known: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> !$isunknown(wb_rd_addr))
        else $error("wb_rd_addr unknown while wb_valid is high");

endmodule

bind pipeline pipeline_checker checker_i (
    .clk         ( clk ),
    .rst         ( rst ),
    .instr_valid ( instr_valid ),
    .instr       ( instr ),
    .wb_valid    ( wb_valid ),
    .wb_rd_addr  ( wb_rd_addr )
);

/* bench/pipeline_tb.sv */
`timescale 1ns/1ps

`include "pipeline_consts.svh"

module pipeline_tb
    import pipeline_pkg::*;
();

    localparam int rand_count = 200;

    // Random form selection, padded to power of two sizes
    localparam logic [5:0] fn_tab [16] = '{
        `FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU,
        `FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV, `FN_ADDU, `FN_SUBU
    };
    localparam logic [5:0] op_tab [8] = '{
        `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI, `OP_ADDIU
    };

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic        wb_valid;
    logic [4:0]  wb_rd_addr;
    logic [31:0] wb_data;

    // Stimulus table and outstanding results
    string       row_name [$];
    logic [31:0] row_word [$];
    bit          row_wb [$];
    logic [4:0]  row_dest [$];
    logic [31:0] row_value [$];
    string       exp_name [$];
    logic [4:0]  exp_dest [$];
    logic [31:0] exp_data [$];

    logic [31:0] model_regs [32];
    int          cycles;
    int          limit;

    pipeline pipeline_i (
        .clk         ( clk ),
        .rst         ( rst ),
        .instr_valid ( instr_valid ),
        .instr       ( instr ),
        .wb_valid    ( wb_valid ),
        .wb_rd_addr  ( wb_rd_addr ),
        .wb_data     ( wb_data )
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Encoding, random source and reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] shamt);
        return {`OP_RTYPE, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Architectural result from the current model registers
    function automatic logic [31:0] model_result(input logic [31:0] word);
        instr_u      w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        w    = word;
        a    = model_regs[w.r.rs];
        b    = model_regs[w.r.rt];
        simm = {{16{w.i.imm[15]}}, w.i.imm};
        zimm = {16'h0000, w.i.imm};
        case (w.r.opcode)
            `OP_RTYPE: begin
                case (w.r.funct)
                    `FN_ADDU: return a + b;
                    `FN_SUBU: return a - b;
                    `FN_AND:  return a & b;
                    `FN_OR:   return a | b;
                    `FN_XOR:  return a ^ b;
                    `FN_NOR:  return ~(a | b);
                    `FN_SLT:  return {31'b0, $signed(a) < $signed(b)};
                    `FN_SLTU: return {31'b0, a < b};
                    `FN_SLL:  return b << w.r.shamt;
                    `FN_SRL:  return b >> w.r.shamt;
                    `FN_SRA:  return $unsigned($signed(b) >>> w.r.shamt);
                    // Variable amount is rs modulo 32
                    `FN_SLLV: return b << a[4:0];
                    `FN_SRLV: return b >> a[4:0];
                    `FN_SRAV: return $unsigned($signed(b) >>> a[4:0]);
                    default:  return 32'h0;
                endcase
            end
            `OP_ADDIU: return a + simm;
            `OP_SLTI:  return {31'b0, $signed(a) < $signed(simm)};
            `OP_SLTIU: return {31'b0, a < simm};
            `OP_ANDI:  return a & zimm;
            `OP_ORI:   return a | zimm;
            `OP_XORI:  return a ^ zimm;
            `OP_LUI:   return {w.i.imm, 16'h0000};
            default:   return 32'h0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Tasks
    ////////////////////////////////////////////////////////////

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_row(input string name, input logic [31:0] word, input bit wb,
                           input logic [4:0] dest, input logic [31:0] value);
        row_name.push_back(name);
        row_word.push_back(word);
        row_wb.push_back(wb);
        row_dest.push_back(dest);
        row_value.push_back(value);
    endtask

    // Drive one word, then step to the next drive point
    task automatic issue(input string name, input logic [31:0] word, input bit wb,
                         input logic [4:0] dest, input logic [31:0] value);
        instr_valid = 1'b1;
        instr       = word;
        if (wb) begin
            exp_name.push_back(name);
            exp_dest.push_back(dest);
            exp_data.push_back(value);
            if (dest != 5'd0) model_regs[dest] = value;
        end
        @(posedge clk);
        #2;
    endtask

    task automatic load_table();
        // Constants built by immediates
        add_row("lui", enc_i(`OP_LUI, 5'd0, 5'd1, 16'h8000), 1'b1, 5'd1, 32'h8000_0000);
        add_row("ori", enc_i(`OP_ORI, 5'd1, 5'd1, 16'h0005), 1'b1, 5'd1, 32'h8000_0005);
        add_row("ori r2", enc_i(`OP_ORI, 5'd0, 5'd2, 16'h0003), 1'b1, 5'd2, 32'h0000_0003);
        add_row("addiu", enc_i(`OP_ADDIU, 5'd0, 5'd3, 16'hfff0), 1'b1, 5'd3, 32'hffff_fff0);
        add_row("ori r4", enc_i(`OP_ORI, 5'd0, 5'd4, 16'h1234), 1'b1, 5'd4, 32'h0000_1234);
        // Register form
        add_row("addu", enc_r(`FN_ADDU, 5'd1, 5'd2, 5'd5, 5'd0), 1'b1, 5'd5, 32'h8000_0008);
        add_row("subu", enc_r(`FN_SUBU, 5'd2, 5'd4, 5'd6, 5'd0), 1'b1, 5'd6, 32'hffff_edcf);
        add_row("and", enc_r(`FN_AND, 5'd1, 5'd3, 5'd7, 5'd0), 1'b1, 5'd7, 32'h8000_0000);
        add_row("or", enc_r(`FN_OR, 5'd2, 5'd4, 5'd8, 5'd0), 1'b1, 5'd8, 32'h0000_1237);
        add_row("xor", enc_r(`FN_XOR, 5'd1, 5'd3, 5'd9, 5'd0), 1'b1, 5'd9, 32'h7fff_fff5);
        add_row("nor", enc_r(`FN_NOR, 5'd2, 5'd4, 5'd10, 5'd0), 1'b1, 5'd10, 32'hffff_edc8);
        add_row("slt", enc_r(`FN_SLT, 5'd1, 5'd2, 5'd11, 5'd0), 1'b1, 5'd11, 32'h0000_0001);
        add_row("sltu", enc_r(`FN_SLTU, 5'd1, 5'd2, 5'd12, 5'd0), 1'b1, 5'd12, 32'h0000_0000);
        add_row("sll", enc_r(`FN_SLL, 5'd0, 5'd4, 5'd13, 5'd4), 1'b1, 5'd13, 32'h0001_2340);
        add_row("srl", enc_r(`FN_SRL, 5'd0, 5'd1, 5'd14, 5'd4), 1'b1, 5'd14, 32'h0800_0000);
        add_row("sra", enc_r(`FN_SRA, 5'd0, 5'd1, 5'd15, 5'd4), 1'b1, 5'd15, 32'hf800_0000);
        add_row("sllv", enc_r(`FN_SLLV, 5'd4, 5'd2, 5'd16, 5'd0), 1'b1, 5'd16, 32'h0030_0000);
        add_row("srav", enc_r(`FN_SRAV, 5'd2, 5'd3, 5'd17, 5'd0), 1'b1, 5'd17, 32'hffff_fffe);
        add_row("srlv", enc_r(`FN_SRLV, 5'd1, 5'd3, 5'd18, 5'd0), 1'b1, 5'd18, 32'h07ff_ffff);
        add_row("slti", enc_i(`OP_SLTI, 5'd3, 5'd19, 16'hfff1), 1'b1, 5'd19, 32'h0000_0001);
        add_row("sltiu", enc_i(`OP_SLTIU, 5'd2, 5'd20, 16'hffff), 1'b1, 5'd20, 32'h0000_0001);
        add_row("andi", enc_i(`OP_ANDI, 5'd3, 5'd21, 16'hff0f), 1'b1, 5'd21, 32'h0000_ff00);
        add_row("xori", enc_i(`OP_XORI, 5'd4, 5'd22, 16'hffff), 1'b1, 5'd22, 32'h0000_edcb);
        // Dependents at distance 1, 2 and 3
        add_row("dep src", enc_i(`OP_ADDIU, 5'd0, 5'd23, 16'h0007), 1'b1, 5'd23, 32'd7);
        add_row("dep d1", enc_r(`FN_ADDU, 5'd23, 5'd23, 5'd24, 5'd0), 1'b1, 5'd24, 32'd14);
        add_row("dep d2", enc_r(`FN_ADDU, 5'd23, 5'd24, 5'd25, 5'd0), 1'b1, 5'd25, 32'd21);
        add_row("dep d3", enc_r(`FN_ADDU, 5'd23, 5'd25, 5'd26, 5'd0), 1'b1, 5'd26, 32'd28);
        // Register zero stays zero, bubble leaves no result
        add_row("r0 write", enc_i(`OP_ADDIU, 5'd0, 5'd0, 16'h0055), 1'b1, 5'd0, 32'h55);
        add_row("r0 read", enc_r(`FN_ADDU, 5'd0, 5'd0, 5'd27, 5'd0), 1'b1, 5'd27, 32'h0);
        add_row("bubble", 32'hfc00_0000, 1'b0, 5'd0, 32'h0);
        add_row("after", enc_i(`OP_ORI, 5'd0, 5'd28, 16'h00aa), 1'b1, 5'd28, 32'h0000_00aa);
    endtask

    ////////////////////////////////////////////////////////////
    // Result monitor and timeout
    ////////////////////////////////////////////////////////////

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            if (exp_data.size() == 0) begin
                $display("writeback to r%0d with no instruction outstanding", wb_rd_addr);
                $display("*** FAILED ***");
                $fatal(1, "unexpected writeback");
            end else begin
                check({exp_name[0], " rd"}, {27'b0, exp_dest[0]}, {27'b0, wb_rd_addr});
                check(exp_name[0], exp_data[0], wb_data);
                void'(exp_name.pop_front());
                void'(exp_dest.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles with %0d results missing", cycles,
                     exp_data.size());
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] seed;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] word;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  dest;
        clk         = 1'b0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = 32'h0;
        cycles      = 0;
        seed        = 32'd48;
        for (int i = 0; i < 32; i++) model_regs[i] = 32'h0;
        load_table();
        limit = row_word.size() + rand_count + 20;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        // Directed table, back to back
        for (int i = 0; i < row_word.size(); i++) begin
            issue(row_name[i], row_word[i], row_wb[i], row_dest[i], row_value[i]);
        end
        // Random phase, small register window for dense dependencies
        for (int n = 0; n < rand_count; n++) begin
            r1   = xorshift32(seed);
            r2   = xorshift32(r1);
            seed = r2;
            rs   = {2'b00, r1[7:5]};
            rt   = {2'b00, r1[10:8]};
            rd   = {2'b00, r1[13:11]};
            if (r1[0]) begin
                word = enc_r(fn_tab[r1[4:1]], rs, rt, rd, r2[20:16]);
            end else begin
                word = enc_i(op_tab[r1[3:1]], rs, rt, r2[15:0]);
            end
            dest = (word[31:26] == `OP_RTYPE) ? word[15:11] : word[20:16];
            issue($sformatf("random %0d", n), word, 1'b1, dest, model_result(word));
        end
        instr_valid = 1'b0;
        // Drain, then a few idle cycles where a stray result hits the monitor
        while (exp_data.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+common
common/pipeline_pkg.sv
common/ex_bus_if.sv
rtl/gpr.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/pipeline.sv
bench/pipeline_checker.sv
bench/pipeline_tb.sv

/* Makefile */
# Verilator build and run of the pipeline testbench

VERILATOR ?= verilator
TOP       ?= pipeline_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -qF '*** PASSED ***' $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
